/* design/mips_pkg.sv */
`default_nettype none

package mips_pkg;

    // widths fixed by the ISA
    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int REG_COUNT  = 32;

    // primary opcode field
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f
    } opcode_e;

    // funct field of SPECIAL
    typedef enum logic [5:0] {
        FN_SLL   = 6'h00,
        FN_SRL   = 6'h02,
        FN_SRA   = 6'h03,
        FN_MFHI  = 6'h10,
        FN_MTHI  = 6'h11,
        FN_MFLO  = 6'h12,
        FN_MTLO  = 6'h13,
        FN_MULT  = 6'h18,
        FN_MULTU = 6'h19,
        FN_ADDU  = 6'h21,
        FN_SUBU  = 6'h23,
        FN_AND   = 6'h24,
        FN_OR    = 6'h25,
        FN_XOR   = 6'h26,
        FN_NOR   = 6'h27,
        FN_SLT   = 6'h2a,
        FN_SLTU  = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    typedef enum logic [2:0] {
        HL_NONE, HL_MULT, HL_MULTU, HL_MTHI, HL_MTLO
    } hilo_op_e;

    typedef enum logic [1:0] {
        WB_ALU, WB_HI, WB_LO
    } wb_src_e;

endpackage

`default_nettype wire

/* design/regfile.sv */
`timescale 1ns/10ps
`default_nettype none

module regfile
    import mips_pkg::*;
(
    input  logic                  clock_i,
    input  logic                  arst_n_i,
    input  logic [REG_ADDR_W-1:0] rs_addr_i,
    input  logic [REG_ADDR_W-1:0] rt_addr_i,
    input  logic                  we_i,
    input  logic [REG_ADDR_W-1:0] waddr_i,
    input  logic [DATA_W-1:0]     wdata_i,
    output logic [DATA_W-1:0]     rs_data_o,
    output logic [DATA_W-1:0]     rt_data_o
);

    logic [DATA_W-1:0] regs [REG_COUNT];

    always_ff @(posedge clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // $zero reads as constant
    assign rs_data_o = (rs_addr_i == '0) ? '0 : regs[rs_addr_i];
    assign rt_data_o = (rt_addr_i == '0) ? '0 : regs[rt_addr_i];

endmodule

`default_nettype wire

/* design/alu_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_unit
    import mips_pkg::*;
(
    input  alu_op_e           alu_op_i,
    input  logic [DATA_W-1:0] a_i,
    input  logic [DATA_W-1:0] b_i,
    output logic [DATA_W-1:0] result_o
);

    logic [4:0]        shamt;
    logic              lt_signed;
    logic              lt_unsigned;

    // shift amount rides in operand a
    assign shamt       = a_i[4:0];
    assign lt_signed   = $signed(a_i) < $signed(b_i);
    assign lt_unsigned = a_i < b_i;

    always_comb begin
        case (alu_op_i)
            ALU_ADD:  result_o = a_i + b_i;
            ALU_SUB:  result_o = a_i - b_i;
            ALU_AND:  result_o = a_i & b_i;
            ALU_OR:   result_o = a_i | b_i;
            ALU_XOR:  result_o = a_i ^ b_i;
            ALU_NOR:  result_o = ~(a_i | b_i);
            ALU_SLT:  result_o = {{(DATA_W-1){1'b0}}, lt_signed};
            ALU_SLTU: result_o = {{(DATA_W-1){1'b0}}, lt_unsigned};
            ALU_SLL:  result_o = b_i << shamt;
            ALU_SRL:  result_o = b_i >> shamt;
            ALU_SRA:  result_o = $unsigned($signed(b_i) >>> shamt);
            // immediate into the upper half
            ALU_LUI:  result_o = {b_i[15:0], 16'h0000};
            default:  result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* design/hilo_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module hilo_unit
    import mips_pkg::*;
(
    input  logic              clock_i,
    input  logic              arst_n_i,
    input  logic              valid_i,
    input  hilo_op_e          hilo_op_i,
    input  wb_src_e           wb_src_i,
    input  logic [DATA_W-1:0] a_i,
    input  logic [DATA_W-1:0] b_i,
    output logic [DATA_W-1:0] result_o
);

    logic [DATA_W-1:0]          hi_q, lo_q;
    logic                       signed_mul;
    logic signed [DATA_W:0]     a_ext, b_ext;
    logic signed [2*DATA_W+1:0] prod;

    // one 33x33 signed multiplier serves mult and multu
    assign signed_mul = (hilo_op_i == HL_MULT);
    assign a_ext      = {signed_mul & a_i[DATA_W-1], a_i};
    assign b_ext      = {signed_mul & b_i[DATA_W-1], b_i};
    assign prod       = a_ext * b_ext;

    always_ff @(posedge clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hi_q <= '0;
            lo_q <= '0;
        end else if (valid_i) begin
            case (hilo_op_i)
                HL_MULT, HL_MULTU: begin
                    hi_q <= prod[2*DATA_W-1:DATA_W];
                    lo_q <= prod[DATA_W-1:0];
                end
                HL_MTHI: hi_q <= a_i;
                HL_MTLO: lo_q <= a_i;
                default: begin
                    hi_q <= hi_q;
                    lo_q <= lo_q;
                end
            endcase
        end
    end

    // mfhi / mflo read path
    assign result_o = (wb_src_i == WB_HI) ? hi_q : lo_q;

endmodule

`default_nettype wire

/* design/wb_select.sv */
`timescale 1ns/10ps
`default_nettype none

module wb_select
    import mips_pkg::*;
(
    input  logic                  clock_i,
    input  logic                  arst_n_i,
    input  logic                  valid_i,
    input  logic                  we_i,
    input  logic [REG_ADDR_W-1:0] dest_i,
    input  wb_src_e               wb_src_i,
    input  logic [DATA_W-1:0]     alu_result_i,
    input  logic [DATA_W-1:0]     hilo_result_i,

    output logic                  ex_fwd_we_o,
    output logic [REG_ADDR_W-1:0] ex_fwd_addr_o,
    output logic [DATA_W-1:0]     ex_fwd_data_o,

    output logic                  wb_we_o,
    output logic [REG_ADDR_W-1:0] wb_addr_o,
    output logic [DATA_W-1:0]     wb_data_o
);

    // execute-stage result, also the forwarding source
    assign ex_fwd_we_o   = valid_i & we_i;
    assign ex_fwd_addr_o = dest_i;
    assign ex_fwd_data_o = (wb_src_i == WB_ALU) ? alu_result_i : hilo_result_i;

    always_ff @(posedge clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_we_o <= 1'b0;
        end else begin
            wb_we_o <= ex_fwd_we_o;
        end
    end

    always_ff @(posedge clock_i) begin
        wb_addr_o <= ex_fwd_addr_o;
        wb_data_o <= ex_fwd_data_o;
    end

endmodule

`default_nettype wire

/* design/decode_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module decode_stage
    import mips_pkg::*;
(
    input  logic                  clock_i,
    input  logic                  arst_n_i,

    input  logic                  inst_valid_i,
    input  logic [DATA_W-1:0]     inst_i,

    input  logic [DATA_W-1:0]     rs_data_i,
    input  logic [DATA_W-1:0]     rt_data_i,

    input  logic                  ex_fwd_we_i,
    input  logic [REG_ADDR_W-1:0] ex_fwd_addr_i,
    input  logic [DATA_W-1:0]     ex_fwd_data_i,
    input  logic                  wb_we_i,
    input  logic [REG_ADDR_W-1:0] wb_addr_i,
    input  logic [DATA_W-1:0]     wb_data_i,

    output logic [REG_ADDR_W-1:0] rs_addr_o,
    output logic [REG_ADDR_W-1:0] rt_addr_o,

    output logic                  ex_valid_o,
    output alu_op_e               ex_alu_op_o,
    output hilo_op_e              ex_hilo_op_o,
    output wb_src_e               ex_wb_src_o,
    output logic [DATA_W-1:0]     ex_a_o,
    output logic [DATA_W-1:0]     ex_b_o,
    output logic [REG_ADDR_W-1:0] ex_dest_o,
    output logic                  ex_we_o
);

    logic                  inst_valid_q;
    logic [DATA_W-1:0]     inst_q;

    opcode_e               opcode;
    funct_e                funct;
    logic [DATA_W-1:0]     rs_val, rt_val;
    logic [DATA_W-1:0]     imm_sext, imm_zext, shamt;

    alu_op_e               alu_op_d;
    hilo_op_e              hilo_op_d;
    wb_src_e               wb_src_d;
    logic [DATA_W-1:0]     a_d, b_d;
    logic [REG_ADDR_W-1:0] dest_d;
    logic                  we_d;

    // instruction register
    always_ff @(posedge clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            inst_valid_q <= 1'b0;
        end else begin
            inst_valid_q <= inst_valid_i;
        end
    end

    always_ff @(posedge clock_i) begin
        inst_q <= inst_i;
    end

    assign opcode    = opcode_e'(inst_q[31:26]);
    assign funct     = funct_e'(inst_q[5:0]);
    assign rs_addr_o = inst_q[25:21];
    assign rt_addr_o = inst_q[20:16];
    assign imm_sext  = {{(DATA_W-16){inst_q[15]}}, inst_q[15:0]};
    assign imm_zext  = {{(DATA_W-16){1'b0}}, inst_q[15:0]};
    assign shamt     = {{(DATA_W-5){1'b0}}, inst_q[10:6]};

    // execute result is newest, then writeback, then the register file
    function automatic logic [DATA_W-1:0] fwd_sel(
        input logic [REG_ADDR_W-1:0] addr,
        input logic [DATA_W-1:0]     rf_data
    );
        if (ex_fwd_we_i && ex_fwd_addr_i == addr) begin
            return ex_fwd_data_i;
        end else if (wb_we_i && wb_addr_i == addr) begin
            return wb_data_i;
        end
        return rf_data;
    endfunction

    always_comb begin
        rs_val = fwd_sel(rs_addr_o, rs_data_i);
        rt_val = fwd_sel(rt_addr_o, rt_data_i);
    end

    always_comb begin
        alu_op_d  = ALU_ADD;
        hilo_op_d = HL_NONE;
        wb_src_d  = WB_ALU;
        a_d       = rs_val;
        b_d       = rt_val;
        dest_d    = inst_q[15:11];
        we_d      = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                case (funct)
                    FN_SLL:   begin alu_op_d = ALU_SLL;  a_d = shamt; we_d = 1'b1; end
                    FN_SRL:   begin alu_op_d = ALU_SRL;  a_d = shamt; we_d = 1'b1; end
                    FN_SRA:   begin alu_op_d = ALU_SRA;  a_d = shamt; we_d = 1'b1; end
                    FN_ADDU:  begin alu_op_d = ALU_ADD;  we_d = 1'b1; end
                    FN_SUBU:  begin alu_op_d = ALU_SUB;  we_d = 1'b1; end
                    FN_AND:   begin alu_op_d = ALU_AND;  we_d = 1'b1; end
                    FN_OR:    begin alu_op_d = ALU_OR;   we_d = 1'b1; end
                    FN_XOR:   begin alu_op_d = ALU_XOR;  we_d = 1'b1; end
                    FN_NOR:   begin alu_op_d = ALU_NOR;  we_d = 1'b1; end
                    FN_SLT:   begin alu_op_d = ALU_SLT;  we_d = 1'b1; end
                    FN_SLTU:  begin alu_op_d = ALU_SLTU; we_d = 1'b1; end
                    FN_MFHI:  begin wb_src_d = WB_HI;    we_d = 1'b1; end
                    FN_MFLO:  begin wb_src_d = WB_LO;    we_d = 1'b1; end
                    FN_MTHI:  hilo_op_d = HL_MTHI;
                    FN_MTLO:  hilo_op_d = HL_MTLO;
                    FN_MULT:  hilo_op_d = HL_MULT;
                    FN_MULTU: hilo_op_d = HL_MULTU;
                    default:  we_d = 1'b0;
                endcase
            end
            OP_ADDIU: begin alu_op_d = ALU_ADD;  b_d = imm_sext; we_d = 1'b1; end
            OP_SLTI:  begin alu_op_d = ALU_SLT;  b_d = imm_sext; we_d = 1'b1; end
            OP_SLTIU: begin alu_op_d = ALU_SLTU; b_d = imm_sext; we_d = 1'b1; end
            OP_ANDI:  begin alu_op_d = ALU_AND;  b_d = imm_zext; we_d = 1'b1; end
            OP_ORI:   begin alu_op_d = ALU_OR;   b_d = imm_zext; we_d = 1'b1; end
            OP_XORI:  begin alu_op_d = ALU_XOR;  b_d = imm_zext; we_d = 1'b1; end
            OP_LUI:   begin alu_op_d = ALU_LUI;  b_d = imm_zext; we_d = 1'b1; end
            default:  we_d = 1'b0;
        endcase
        // I-type results go to rt
        if (opcode != OP_SPECIAL) begin
            dest_d = inst_q[20:16];
        end
        if (dest_d == '0) begin
            we_d = 1'b0;
        end
    end

    // decode to execute register
    always_ff @(posedge clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_valid_o   <= 1'b0;
            ex_we_o      <= 1'b0;
            ex_hilo_op_o <= HL_NONE;
        end else begin
            ex_valid_o   <= inst_valid_q;
            ex_we_o      <= we_d;
            ex_hilo_op_o <= hilo_op_d;
        end
    end

    always_ff @(posedge clock_i) begin
        ex_alu_op_o <= alu_op_d;
        ex_wb_src_o <= wb_src_d;
        ex_a_o      <= a_d;
        ex_b_o      <= b_d;
        ex_dest_o   <= dest_d;
    end

endmodule

`default_nettype wire

/* design/exec_pipe_top.sv */
`timescale 1ns/10ps
`default_nettype none

module exec_pipe_top
    import mips_pkg::*;
(
    input  logic                  clock_i,
    input  logic                  arst_n_i,

    input  logic                  inst_valid_i,
    input  logic [DATA_W-1:0]     inst_i,

    output logic                  debug_wb_we_o,
    output logic [REG_ADDR_W-1:0] debug_wb_num_o,
    output logic [DATA_W-1:0]     debug_wb_data_o
);

    logic [REG_ADDR_W-1:0] rs_addr, rt_addr;
    logic [DATA_W-1:0]     rs_data, rt_data;

    logic                  ex_valid;
    alu_op_e               ex_alu_op;
    hilo_op_e              ex_hilo_op;
    wb_src_e               ex_wb_src;
    logic [DATA_W-1:0]     ex_a, ex_b;
    logic [REG_ADDR_W-1:0] ex_dest;
    logic                  ex_we;

    logic [DATA_W-1:0]     alu_result;
    logic [DATA_W-1:0]     hilo_result;

    logic                  ex_fwd_we;
    logic [REG_ADDR_W-1:0] ex_fwd_addr;
    logic [DATA_W-1:0]     ex_fwd_data;
    logic                  wb_we;
    logic [REG_ADDR_W-1:0] wb_addr;
    logic [DATA_W-1:0]     wb_data;

    // every register write is visible on the debug port
    assign debug_wb_we_o   = wb_we;
    assign debug_wb_num_o  = wb_addr;
    assign debug_wb_data_o = wb_data;

    decode_stage decode_stage_i (
        .clock_i      (clock_i),
        .arst_n_i     (arst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .rs_data_i    (rs_data),
        .rt_data_i    (rt_data),
        .ex_fwd_we_i  (ex_fwd_we),
        .ex_fwd_addr_i(ex_fwd_addr),
        .ex_fwd_data_i(ex_fwd_data),
        .wb_we_i      (wb_we),
        .wb_addr_i    (wb_addr),
        .wb_data_i    (wb_data),
        .rs_addr_o    (rs_addr),
        .rt_addr_o    (rt_addr),
        .ex_valid_o   (ex_valid),
        .ex_alu_op_o  (ex_alu_op),
        .ex_hilo_op_o (ex_hilo_op),
        .ex_wb_src_o  (ex_wb_src),
        .ex_a_o       (ex_a),
        .ex_b_o       (ex_b),
        .ex_dest_o    (ex_dest),
        .ex_we_o      (ex_we)
    );

    regfile regfile_i (
        .clock_i  (clock_i),
        .arst_n_i (arst_n_i),
        .rs_addr_i(rs_addr),
        .rt_addr_i(rt_addr),
        .we_i     (wb_we),
        .waddr_i  (wb_addr),
        .wdata_i  (wb_data),
        .rs_data_o(rs_data),
        .rt_data_o(rt_data)
    );

    alu_unit alu_unit_i (
        .alu_op_i(ex_alu_op),
        .a_i     (ex_a),
        .b_i     (ex_b),
        .result_o(alu_result)
    );

    hilo_unit hilo_unit_i (
        .clock_i  (clock_i),
        .arst_n_i (arst_n_i),
        .valid_i  (ex_valid),
        .hilo_op_i(ex_hilo_op),
        .wb_src_i (ex_wb_src),
        .a_i      (ex_a),
        .b_i      (ex_b),
        .result_o (hilo_result)
    );

    wb_select wb_select_i (
        .clock_i      (clock_i),
        .arst_n_i     (arst_n_i),
        .valid_i      (ex_valid),
        .we_i         (ex_we),
        .dest_i       (ex_dest),
        .wb_src_i     (ex_wb_src),
        .alu_result_i (alu_result),
        .hilo_result_i(hilo_result),
        .ex_fwd_we_o  (ex_fwd_we),
        .ex_fwd_addr_o(ex_fwd_addr),
        .ex_fwd_data_o(ex_fwd_data),
        .wb_we_o      (wb_we),
        .wb_addr_o    (wb_addr),
        .wb_data_o    (wb_data)
    );

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic clock_o
);

    localparam int HALF_PERIOD_NS = 2;

    initial begin
        clock_o = 1'b0;
        forever begin
            #(HALF_PERIOD_NS) clock_o = ~clock_o;
        end
    end

endmodule

`default_nettype wire

/* testbench/exec_pipe_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module exec_pipe_tb
    import mips_pkg::*;
();

    localparam int RESET_CYCLES   = 8;
    localparam int RAND_COUNT     = 300;
    // upper bound on directed issue slots including bubbles
    localparam int DIRECTED_SLOTS = 120;
    localparam int DRAIN_CYCLES   = 8;
    localparam int TEST_COUNT     = 6;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + DIRECTED_SLOTS + 2 * RAND_COUNT
                                  + DRAIN_CYCLES * TEST_COUNT + 50;

    logic                  clock_i;
    logic                  arst_n_i;
    logic                  inst_valid_i;
    logic [DATA_W-1:0]     inst_i;
    logic                  debug_wb_we_o;
    logic [REG_ADDR_W-1:0] debug_wb_num_o;
    logic [DATA_W-1:0]     debug_wb_data_o;

    logic [DATA_W-1:0]            model_regs [REG_COUNT];
    logic [DATA_W-1:0]            model_hi;
    logic [DATA_W-1:0]            model_lo;
    logic [REG_ADDR_W+DATA_W-1:0] exp_q [$];
    logic [15:0]                  lfsr_state;
    string                        test_name;
    int error_count  = 0;
    int check_count  = 0;
    int test_count   = 0;
    int failed_tests = 0;
    int errors_before = 0;
    int cycle_count  = 0;

    tb_clock_gen tb_clock_gen_i (.clock_o(clock_i));

    exec_pipe_top exec_pipe_top_i (
        .clock_i        (clock_i),
        .arst_n_i       (arst_n_i),
        .inst_valid_i   (inst_valid_i),
        .inst_i         (inst_i),
        .debug_wb_we_o  (debug_wb_we_o),
        .debug_wb_num_o (debug_wb_num_o),
        .debug_wb_data_o(debug_wb_data_o)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [31:0] make_rtype(input logic [5:0] fn, input int rs, input int rt,
                                               input int rd, input int sh);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
    endfunction

    function automatic logic [31:0] make_itype(input logic [5:0] op, input int rs, input int rt,
                                               input int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    // architectural model in issue order
    // returns 1 when the instruction writes a register
    function automatic logic ref_execute(input logic [31:0] inst, output logic [4:0] num,
                                         output logic [31:0] data);
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [4:0]  sh;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sext;
        logic [31:0] zext;
        logic [63:0] prod;
        logic        we;
        op   = inst[31:26];
        fn   = inst[5:0];
        sh   = inst[10:6];
        a    = model_regs[inst[25:21]];
        b    = model_regs[inst[20:16]];
        sext = {{16{inst[15]}}, inst[15:0]};
        zext = {16'h0000, inst[15:0]};
        we   = 1'b1;
        num  = inst[20:16];
        data = '0;
        if (op == OP_SPECIAL) begin
            num = inst[15:11];
            case (fn)
                FN_SLL:  data = b << sh;
                FN_SRL:  data = b >> sh;
                FN_SRA:  data = (b >> sh) | ({32{b[31]}} & ~(32'hffff_ffff >> sh));
                FN_ADDU: data = a + b;
                FN_SUBU: data = a - b;
                FN_AND:  data = a & b;
                FN_OR:   data = a | b;
                FN_XOR:  data = a ^ b;
                FN_NOR:  data = ~(a | b);
                FN_SLT:  data = {31'b0, $signed(a) < $signed(b)};
                FN_SLTU: data = {31'b0, a < b};
                FN_MFHI: data = model_hi;
                FN_MFLO: data = model_lo;
                FN_MTHI: begin
                    model_hi = a;
                    we = 1'b0;
                end
                FN_MTLO: begin
                    model_lo = a;
                    we = 1'b0;
                end
                FN_MULT, FN_MULTU: begin
                    if (fn == FN_MULT) begin
                        prod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
                    end else begin
                        prod = {32'h0, a} * {32'h0, b};
                    end
                    model_hi = prod[63:32];
                    model_lo = prod[31:0];
                    we = 1'b0;
                end
                default: we = 1'b0;
            endcase
        end else begin
            case (op)
                OP_ADDIU: data = a + sext;
                OP_SLTI:  data = {31'b0, $signed(a) < $signed(sext)};
                OP_SLTIU: data = {31'b0, a < sext};
                OP_ANDI:  data = a & zext;
                OP_ORI:   data = a | zext;
                OP_XORI:  data = a ^ zext;
                OP_LUI:   data = {inst[15:0], 16'h0000};
                default:  we = 1'b0;
            endcase
        end
        if (num == 5'd0) begin
            we = 1'b0;
        end
        if (we) begin
            model_regs[num] = data;
        end
        return we;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        check_count++;
        if (got !== expected) begin
            $display("error: time %0t %s got %h expected %h", $time, name, got, expected);
            error_count++;
        end
    endtask

    task automatic issue(input logic [31:0] inst);
        logic [4:0]  num;
        logic [31:0] data;
        @(posedge clock_i);
        inst_valid_i <= 1'b1;
        inst_i       <= inst;
        if (ref_execute(inst, num, data)) begin
            exp_q.push_back({num, data});
        end
    endtask

    // the word on inst_i is ignored while valid is low
    task automatic bubble(input logic [31:0] junk);
        @(posedge clock_i);
        inst_valid_i <= 1'b0;
        inst_i       <= junk;
    endtask

    task automatic drain_pipe();
        while (exp_q.size() != 0) begin
            bubble('0);
        end
        repeat (4) bubble('0);
    endtask

    task automatic start_test(input string name);
        test_name     = name;
        errors_before = error_count;
    endtask

    task automatic finish_test();
        int errs;
        drain_pipe();
        errs = error_count - errors_before;
        test_count++;
        if (errs == 0) begin
            $display("test %0d %s: ok", test_count, test_name);
        end else begin
            failed_tests++;
            $display("test %0d %s: %0d errors", test_count, test_name, errs);
        end
    endtask

    task automatic run_rtype_ops();
        start_test("r-type alu");
        issue(make_itype(OP_LUI, 0, 1, 16'h8000));
        issue(make_itype(OP_ORI, 1, 1, 16'h1234));
        issue(make_itype(OP_LUI, 0, 2, 16'h7fff));
        issue(make_itype(OP_ORI, 2, 2, 16'hfff0));
        issue(make_itype(OP_ORI, 0, 3, 16'h0005));
        issue(make_rtype(FN_ADDU, 1, 2, 4, 0));
        issue(make_rtype(FN_SUBU, 1, 2, 5, 0));
        issue(make_rtype(FN_AND, 1, 2, 6, 0));
        issue(make_rtype(FN_OR, 1, 3, 7, 0));
        issue(make_rtype(FN_XOR, 1, 2, 8, 0));
        issue(make_rtype(FN_NOR, 1, 3, 9, 0));
        issue(make_rtype(FN_SLT, 1, 2, 10, 0));
        issue(make_rtype(FN_SLTU, 1, 2, 11, 0));
        issue(make_rtype(FN_SLT, 2, 1, 15, 0));
        issue(make_rtype(FN_SLTU, 2, 1, 16, 0));
        issue(make_rtype(FN_SLL, 0, 1, 12, 4));
        issue(make_rtype(FN_SRL, 0, 1, 13, 7));
        issue(make_rtype(FN_SRA, 0, 1, 14, 7));
        finish_test();
    endtask

    task automatic run_itype_ops();
        start_test("i-type alu");
        issue(make_itype(OP_ADDIU, 0, 1, 16'hfff0));
        issue(make_itype(OP_SLTI, 1, 2, 16'hffff));
        issue(make_itype(OP_SLTIU, 1, 3, 16'hffff));
        issue(make_itype(OP_SLTI, 3, 4, 16'h8000));
        issue(make_itype(OP_ANDI, 1, 5, 16'hff0f));
        issue(make_itype(OP_ORI, 0, 6, 16'h8001));
        issue(make_itype(OP_XORI, 1, 7, 16'hffff));
        issue(make_itype(OP_LUI, 0, 8, 16'habcd));
        issue(make_itype(OP_ADDIU, 8, 9, 16'h8000));
        // register 0 as destination
        issue(make_itype(OP_ADDIU, 1, 0, 16'h0005));
        issue(make_itype(OP_LUI, 0, 0, 16'h1234));
        issue(make_rtype(FN_ADDU, 1, 8, 0, 0));
        // encodings outside the kept set
        issue({6'h3f, 5'd1, 5'd2, 16'h1234});
        issue(make_rtype(6'h3f, 1, 2, 3, 0));
        issue({6'h08, 5'd1, 5'd4, 16'h0010});
        issue(make_itype(OP_ORI, 0, 10, 16'h0000));
        finish_test();
    endtask

    task automatic run_forwarding();
        logic [31:0] junk;
        junk = make_itype(OP_ORI, 0, 7, 16'hbeef);
        start_test("forwarding");
        for (int g = 0; g < 4; g++) begin
            issue(make_itype(OP_ORI, 0, 1, 16'h0100 + g));
            repeat (g) bubble(junk);
            issue(make_itype(OP_ADDIU, 1, 1, 16'hffff));
            repeat (g) bubble(junk);
            issue(make_rtype(FN_ADDU, 1, 1, 2, 0));
            repeat (g) bubble(junk);
            issue(make_rtype(FN_SUBU, 2, 1, 3, 0));
        end
        // execute copy must win over the older writeback copy
        issue(make_itype(OP_ADDIU, 0, 4, 16'h0001));
        issue(make_itype(OP_ADDIU, 0, 4, 16'h0002));
        issue(make_rtype(FN_ADDU, 4, 4, 5, 0));
        finish_test();
    endtask

    task automatic run_hilo_ops();
        start_test("hi/lo");
        issue(make_itype(OP_LUI, 0, 1, 16'h8000));
        issue(make_itype(OP_LUI, 0, 2, 16'h7fff));
        issue(make_itype(OP_ORI, 2, 2, 16'hffff));
        issue(make_itype(OP_ADDIU, 0, 3, 16'hffff));
        issue(make_rtype(FN_MULT, 1, 1, 0, 0));
        issue(make_rtype(FN_MFHI, 0, 0, 4, 0));
        issue(make_rtype(FN_MFLO, 0, 0, 5, 0));
        issue(make_rtype(FN_MULT, 1, 2, 0, 0));
        issue(make_rtype(FN_MFHI, 0, 0, 6, 0));
        issue(make_rtype(FN_MFLO, 0, 0, 7, 0));
        issue(make_rtype(FN_MULTU, 3, 3, 0, 0));
        issue(make_rtype(FN_MFHI, 0, 0, 8, 0));
        issue(make_rtype(FN_MFLO, 0, 0, 9, 0));
        issue(make_rtype(FN_MULT, 3, 1, 0, 0));
        issue(make_rtype(FN_MFHI, 0, 0, 10, 0));
        issue(make_rtype(FN_MFLO, 0, 0, 11, 0));
        // rd field on a multiply is ignored
        issue(make_rtype(FN_MULTU, 1, 2, 12, 0));
        bubble('0);
        issue(make_rtype(FN_MFHI, 0, 0, 13, 0));
        issue(make_rtype(FN_MFLO, 0, 0, 14, 0));
        issue(make_rtype(FN_MTHI, 2, 0, 0, 0));
        issue(make_rtype(FN_MTLO, 1, 0, 0, 0));
        issue(make_rtype(FN_MFHI, 0, 0, 15, 0));
        issue(make_rtype(FN_MFLO, 0, 0, 16, 0));
        issue(make_rtype(FN_MTLO, 3, 0, 0, 0));
        issue(make_rtype(FN_MFLO, 0, 0, 17, 0));
        finish_test();
    endtask

    function automatic logic [31:0] random_inst(input logic [4:0] sel, input int rs,
                                                input int rt, input int rd, input int sh,
                                                input int imm);
        case (sel % 5'd24)
            5'd0:    return make_rtype(FN_ADDU, rs, rt, rd, 0);
            5'd1:    return make_rtype(FN_SUBU, rs, rt, rd, 0);
            5'd2:    return make_rtype(FN_AND, rs, rt, rd, 0);
            5'd3:    return make_rtype(FN_OR, rs, rt, rd, 0);
            5'd4:    return make_rtype(FN_XOR, rs, rt, rd, 0);
            5'd5:    return make_rtype(FN_NOR, rs, rt, rd, 0);
            5'd6:    return make_rtype(FN_SLT, rs, rt, rd, 0);
            5'd7:    return make_rtype(FN_SLTU, rs, rt, rd, 0);
            5'd8:    return make_rtype(FN_SLL, 0, rt, rd, sh);
            5'd9:    return make_rtype(FN_SRL, 0, rt, rd, sh);
            5'd10:   return make_rtype(FN_SRA, 0, rt, rd, sh);
            5'd11:   return make_itype(OP_ADDIU, rs, rt, imm);
            5'd12:   return make_itype(OP_SLTI, rs, rt, imm);
            5'd13:   return make_itype(OP_SLTIU, rs, rt, imm);
            5'd14:   return make_itype(OP_ANDI, rs, rt, imm);
            5'd15:   return make_itype(OP_ORI, rs, rt, imm);
            5'd16:   return make_itype(OP_XORI, rs, rt, imm);
            5'd17:   return make_itype(OP_LUI, 0, rt, imm);
            5'd18:   return make_rtype(FN_MULT, rs, rt, 0, 0);
            5'd19:   return make_rtype(FN_MULTU, rs, rt, 0, 0);
            5'd20:   return make_rtype(FN_MTHI, rs, 0, 0, 0);
            5'd21:   return make_rtype(FN_MTLO, rs, 0, 0, 0);
            5'd22:   return make_rtype(FN_MFHI, 0, 0, rd, 0);
            default: return make_rtype(FN_MFLO, 0, 0, rd, 0);
        endcase
    endfunction

    task automatic run_random_mix();
        logic [31:0] v;
        logic [31:0] sel;
        logic [31:0] rs;
        logic [31:0] rt;
        logic [31:0] rd;
        logic [31:0] sh;
        logic [31:0] imm;
        start_test("random mix");
        for (int n = 0; n < RAND_COUNT; n++) begin
            take_bits(1, v);
            if (v[0]) begin
                take_bits(32, v);
                bubble(v);
            end
            take_bits(5, sel);
            take_bits(3, rs);
            take_bits(3, rt);
            take_bits(3, rd);
            take_bits(5, sh);
            take_bits(16, imm);
            issue(random_inst(sel[4:0], rs, rt, rd, sh, imm));
        end
        finish_test();
    endtask

    initial begin
        inst_valid_i = 1'b0;
        inst_i       = '0;
        arst_n_i     = 1'b0;
        lfsr_state   = 16'd53;
        model_hi     = '0;
        model_lo     = '0;
        for (int i = 0; i < REG_COUNT; i++) begin
            model_regs[i] = '0;
        end
        start_test("reset");
        repeat (RESET_CYCLES) @(posedge clock_i);
        arst_n_i <= 1'b1;
        repeat (4) bubble('0);
        issue(make_itype(OP_ORI, 0, 1, 16'h0000));
        finish_test();
        run_rtype_ops();
        run_itype_ops();
        run_forwarding();
        run_hilo_ops();
        run_random_mix();
        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 test_count, failed_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // outputs are stable at the falling edge
    always @(negedge clock_i) begin : compare_writes
        logic [REG_ADDR_W+DATA_W-1:0] exp_entry;
        if (debug_wb_we_o === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("unexpected register write at time %0t: r%0d = %h was not expected",
                         $time, debug_wb_num_o, debug_wb_data_o);
                error_count++;
            end else begin
                exp_entry = exp_q.pop_front();
                check_value("debug_wb_num_o", 32'(debug_wb_num_o), 32'(exp_entry[36:32]));
                check_value("debug_wb_data_o", debug_wb_data_o, exp_entry[31:0]);
            end
        end else if (debug_wb_we_o !== 1'b0) begin
            $display("debug_wb_we_o is unknown at time %0t", $time);
            error_count++;
        end
    end

    always @(posedge clock_i) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles, %0d writes still expected",
                     TIMEOUT_CYCLES, exp_q.size());
            $display("Test failures found");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* exec_pipe_top.f */
design/mips_pkg.sv
design/regfile.sv
design/alu_unit.sv
design/hilo_unit.sv
design/wb_select.sv
design/decode_stage.sv
design/exec_pipe_top.sv
testbench/tb_clock_gen.sv
testbench/exec_pipe_tb.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, then look for the pass line in sim.log
cd "$(dirname "$0")" \
    && verilator --binary --timing -Wno-fatal --top-module exec_pipe_tb \
        -f exec_pipe_top.f -o exec_pipe_sim \
    && ./obj_dir/exec_pipe_sim > sim.log 2>&1 \
    ; cat sim.log 2>/dev/null \
    ; grep -qxF 'All tests passed!' sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
